// ==== Makefile ====
# Verilator build and run for the channel register front end
# any variable below can be set on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_all_channels
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the exit code
run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -Fqx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+dv
src/chan_pkg.sv
src/ipb_io_fsm.sv
src/chan_addr_decode.sv
src/chan_regs.sv
src/readback_mux.sv
src/all_channels_top.sv
dv/tb_all_channels.sv

// ==== dv/tb_ipb_tasks.svh ====
//////////////////////////////
// ipbus master tasks for the channel testbench
// bus access with ack wait, tx strobe driver
//////////////////////////////
`ifndef TB_IPB_TASKS_SVH
`define TB_IPB_TASKS_SVH

// channel field in 23:20, word offset in 7:0
function automatic chan_pkg::ipb_addr_t chan_addr(input int field, input chan_pkg::reg_off_t off);
  return {4'(field), 12'h000, off};
endfunction

task automatic compare_word(input string what, input chan_pkg::ipb_data_t got,
                            input chan_pkg::ipb_data_t exp);
  checks++;
  assert (got === exp) else begin
    $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    errors++;
  end
endtask

// one access, entered and left on a falling edge with the strobe low
// hold keeps the strobe up after ack, tx_mask fires tx strobes with the write
task automatic bus_access(input logic write, input chan_pkg::ipb_addr_t addr,
                          input chan_pkg::ipb_data_t wdata, input int hold,
                          input chan_pkg::chan_sel_t tx_mask, input chan_pkg::ipb_data_t tx_word,
                          output chan_pkg::ipb_data_t rdata);
  int edges;
  bit seen;
  edges      = 0;
  seen       = 1'b0;
  rdata      = '0;
  ipb_strobe = 1'b1;
  ipb_write  = write;
  ipb_addr   = addr;
  ipb_wdata  = wdata;
  while (!seen && edges < ack_wait_max) begin
    @(negedge ipb_clk);
    edges++;
    if (edges == 3) begin               // sampled at E0+3, same edge as the write
      for (int ch = 0; ch < nc; ch++) chan_tx_data[ch] = tx_word;
      chan_tx_valid = tx_mask;
    end else begin
      chan_tx_valid = '0;
    end
    if (ipb_ack) begin
      seen  = 1'b1;
      rdata = ipb_rdata;                // valid together with ack
    end
  end
  chan_tx_valid = '0;
  if (!seen) begin
    $display("timeout: no ipb_ack within %0d cycles for address %h", ack_wait_max, addr);
    errors++;
  end else begin
    checks++;
    // first falling edge follows E0, so an ack after E0+5 shows on the sixth
    assert (edges == ack_latency + 1) else begin
      $display("error at %0t ns: ipb_ack %0d cycles after the strobe, expected %0d",
               $time, edges - 1, ack_latency);
      errors++;
    end
  end
  repeat (hold) begin
    @(negedge ipb_clk);
    checks++;
    assert (!ipb_ack && debug == 4'(chan_pkg::st_release)) else begin
      $display("error at %0t ns: second ipb_ack or state change with the strobe held", $time);
      errors++;
    end
  end
  ipb_strobe = 1'b0;
  ipb_write  = 1'b0;
  @(negedge ipb_clk);                   // strobe low for one edge, fsm back in st_idle
endtask

task automatic bus_write(input chan_pkg::ipb_addr_t addr, input chan_pkg::ipb_data_t wdata);
  chan_pkg::ipb_data_t unused_rd;
  bus_access(1'b1, addr, wdata, 0, '0, '0, unused_rd);
endtask

task automatic bus_read(input chan_pkg::ipb_addr_t addr, output chan_pkg::ipb_data_t rdata);
  bus_access(1'b0, addr, '0, 0, '0, '0, rdata);
endtask

// one cycle of tx strobes, random words, reference follows the enable bits
task automatic pulse_tx_set(input chan_pkg::chan_sel_t mask);
  for (int ch = 0; ch < nc; ch++) begin
    chan_tx_data[ch] = $urandom();
    if (mask[ch] && ref_ctrl[ch][chan_pkg::ctrl_en_bit]) begin
      ref_count[ch] = ref_count[ch] + 1;
      ref_last[ch]  = chan_tx_data[ch];
    end
  end
  chan_tx_valid = mask;
  @(negedge ipb_clk);
  chan_tx_valid = '0;
endtask

`endif

// ==== dv/tb_all_channels.sv ====
//////////////////////////////
// testbench for the link board register front end
// directed bus tests against a register reference model
//////////////////////////////
`timescale 1ns/1ns

module tb_all_channels;

  localparam int ack_wait_max = 32;      // cycles before an access counts as lost
  localparam int ack_latency  = 5;       // strobe sample to ipb_ack
  localparam int nc           = chan_pkg::num_chan;

  logic                         ipb_clk;
  logic                         rst_n;
  logic                         ipb_strobe;
  logic                         ipb_write;
  chan_pkg::ipb_addr_t          ipb_addr;
  chan_pkg::ipb_data_t          ipb_wdata;
  chan_pkg::ipb_data_t          ipb_rdata;
  logic                         ipb_ack;
  chan_pkg::chan_sel_t          chan_tx_valid;
  chan_pkg::ipb_data_t [nc-1:0] chan_tx_data;
  logic [3:0]                   debug;

  //////////////////////////////
  // reference model, one entry per channel
  chan_pkg::ipb_data_t ref_scratch [nc];
  chan_pkg::ipb_data_t ref_ctrl    [nc];
  chan_pkg::ipb_data_t ref_count   [nc];
  chan_pkg::ipb_data_t ref_last    [nc];
  int errors = 0;
  int checks = 0;
  int tests  = 0;

  `include "tb_ipb_tasks.svh"

  initial ipb_clk = 1'b0;
  always #2 ipb_clk = ~ipb_clk;          // 4 ns period

  all_channels_top DUT (
    .ipb_clk       (ipb_clk),
    .rst_n         (rst_n),
    .ipb_strobe    (ipb_strobe),
    .ipb_write     (ipb_write),
    .ipb_addr      (ipb_addr),
    .ipb_wdata     (ipb_wdata),
    .ipb_rdata     (ipb_rdata),
    .ipb_ack       (ipb_ack),
    .chan_tx_valid (chan_tx_valid),
    .chan_tx_data  (chan_tx_data),
    .debug         (debug)
  );

  task automatic finish_test(input string name, input int err_at_start);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err_at_start);
  endtask

  // all channels compared against the model
  task automatic read_all_regs(input string tag);
    chan_pkg::ipb_data_t rd;
    for (int ch = 0; ch < nc; ch++) begin
      bus_read(chan_addr(ch, chan_pkg::reg_ctrl), rd);
      compare_word($sformatf("%s ch%0d ctrl", tag, ch), rd, ref_ctrl[ch]);
      bus_read(chan_addr(ch, chan_pkg::reg_scratch), rd);
      compare_word($sformatf("%s ch%0d scratch", tag, ch), rd, ref_scratch[ch]);
      bus_read(chan_addr(ch, chan_pkg::reg_count), rd);
      compare_word($sformatf("%s ch%0d count", tag, ch), rd, ref_count[ch]);
      bus_read(chan_addr(ch, chan_pkg::reg_last), rd);
      compare_word($sformatf("%s ch%0d last", tag, ch), rd, ref_last[ch]);
    end
  endtask

  //////////////////////////////
  // tests
  task automatic test_reset_values();
    int                  e0;
    chan_pkg::ipb_data_t rd;
    e0 = errors;
    compare_word("debug after reset", 32'(debug), 32'(chan_pkg::st_idle));
    for (int ch = 0; ch < nc; ch++) begin
      bus_read(chan_addr(ch, chan_pkg::reg_ident), rd);   // base plus channel number
      compare_word($sformatf("ch%0d ident", ch), rd, chan_pkg::ident_base + 32'(ch));
    end
    read_all_regs("reset");
    finish_test("reset_values", e0);
  endtask

  task automatic test_scratch();
    int e0;
    e0 = errors;
    for (int ch = 0; ch < nc; ch++) begin
      ref_scratch[ch] = $urandom();
      bus_write(chan_addr(ch, chan_pkg::reg_scratch), ref_scratch[ch]);
    end
    read_all_regs("scratch");              // every channel kept its own word
    finish_test("scratch", e0);
  endtask

  task automatic test_count();
    int e0;
    int n;
    e0 = errors;
    for (int ch = 0; ch < nc; ch++) begin
      ref_ctrl[ch] = 32'($urandom_range(0, 1));            // random enable subset
      bus_write(chan_addr(ch, chan_pkg::reg_ctrl), ref_ctrl[ch]);
    end
    n = $urandom_range(8, 40);
    repeat (n) pulse_tx_set(chan_pkg::chan_sel_t'($urandom()));
    read_all_regs("count");
    finish_test("count", e0);
  endtask

  task automatic test_clear();
    int                  e0;
    int                  c;
    int                  n;
    chan_pkg::ipb_data_t word;
    chan_pkg::ipb_data_t rd;
    e0 = errors;
    for (int ch = 0; ch < nc; ch++) begin
      ref_ctrl[ch] = 32'h1;
      bus_write(chan_addr(ch, chan_pkg::reg_ctrl), ref_ctrl[ch]);
    end
    repeat (6) pulse_tx_set('1);
    c = $urandom_range(0, nc - 1);
    bus_write(chan_addr(c, chan_pkg::reg_ctrl), 32'h3);   // enable stays, clear pulses
    ref_count[c] = '0;
    read_all_regs("clear");                // ctrl reads 1, the clear bit is gone
    n = $urandom_range(2, 9);
    repeat (n) pulse_tx_set(chan_pkg::chan_sel_t'(1) << c);
    bus_read(chan_addr(c, chan_pkg::reg_count), rd);
    compare_word($sformatf("ch%0d count before clear", c), rd, ref_count[c]);
    // clear and tx strobe on the same edge
    word = $urandom();
    bus_access(1'b1, chan_addr(c, chan_pkg::reg_ctrl), 32'h3, 0,
               chan_pkg::chan_sel_t'(1) << c, word, rd);
    ref_count[c] = '0;                     // clear wins
    ref_last[c]  = word;                   // word is still captured
    read_all_regs("clear with strobe");
    finish_test("clear", e0);
  endtask

  task automatic test_unmapped();
    int                  e0;
    chan_pkg::reg_off_t  odd_off [3];
    chan_pkg::ipb_data_t rd;
    e0         = errors;
    odd_off[0] = 8'h05;                    // just past reg_ident
    odd_off[1] = 8'h40;
    odd_off[2] = 8'hff;
    for (int f = nc; f < 16; f++) begin    // fields 8..15 also cover memory space
      bus_write(chan_addr(f, chan_pkg::reg_scratch), $urandom());
      bus_read(chan_addr(f, chan_pkg::reg_scratch), rd);
      compare_word($sformatf("field %0d scratch", f), rd, '0);
      bus_read(chan_addr(f, chan_pkg::reg_ident), rd);
      compare_word($sformatf("field %0d ident", f), rd, '0);
    end
    for (int ch = 0; ch < nc; ch++) begin
      for (int k = 0; k < 3; k++) begin
        bus_write(chan_addr(ch, odd_off[k]), $urandom());
        bus_read(chan_addr(ch, odd_off[k]), rd);
        compare_word($sformatf("ch%0d offset %h", ch, odd_off[k]), rd, '0);
      end
    end
    read_all_regs("unmapped");             // dropped writes left the map alone
    // strobe held 4 cycles past ack
    bus_access(1'b0, chan_addr(1, chan_pkg::reg_scratch), '0, 4, '0, '0, rd);
    compare_word("held strobe scratch", rd, ref_scratch[1]);
    finish_test("unmapped", e0);
  endtask

  //////////////////////////////
  // sequence
  initial begin
    void'($urandom(32'he52c));
    rst_n         = 1'b0;
    ipb_strobe    = 1'b0;
    ipb_write     = 1'b0;
    ipb_addr      = '0;
    ipb_wdata     = '0;
    chan_tx_valid = '0;
    chan_tx_data  = '0;
    for (int ch = 0; ch < nc; ch++) begin
      ref_scratch[ch] = '0;
      ref_ctrl[ch]    = '0;
      ref_count[ch]   = '0;
      ref_last[ch]    = '0;
    end
    repeat (8) @(posedge ipb_clk);
    @(negedge ipb_clk);
    rst_n = 1'b1;
    @(negedge ipb_clk);
    test_reset_values();
    test_scratch();
    test_count();
    test_clear();
    test_unmapped();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== src/all_channels_top.sv ====
//////////////////////////////
// link board register front end top
// bus fsm, decoder, channel blocks and readback mux
//////////////////////////////
`timescale 1ns/1ns

module all_channels_top (
  input  logic                                         ipb_clk,
  input  logic                                         rst_n,
  // ipbus slave side
  input  logic                                         ipb_strobe,
  input  logic                                         ipb_write,
  input  chan_pkg::ipb_addr_t                          ipb_addr,
  input  chan_pkg::ipb_data_t                          ipb_wdata,
  output chan_pkg::ipb_data_t                          ipb_rdata,  // valid with ipb_ack
  output logic                                         ipb_ack,
  // per channel tx strobes
  input  chan_pkg::chan_sel_t                          chan_tx_valid,
  input  chan_pkg::ipb_data_t [chan_pkg::num_chan-1:0] chan_tx_data,
  output logic [3:0]                                   debug       // fsm state
);

  chan_pkg::io_req_t                          io_req;
  chan_pkg::chan_req_t                        chan_req;
  chan_pkg::chan_sel_t                        chan_ack;
  chan_pkg::ipb_data_t [chan_pkg::num_chan-1:0] chan_rd_data;
  logic                                       rsp_ack;
  chan_pkg::ipb_state_e                       fsm_state;

  assign debug = 4'(fsm_state);

  //////////////////////////////
  // bus side
  ipb_io_fsm u_ipb_io_fsm (
    .ipb_clk    (ipb_clk),
    .rst_n      (rst_n),
    .ipb_strobe (ipb_strobe),
    .ipb_write  (ipb_write),
    .ipb_addr   (ipb_addr),
    .ipb_wdata  (ipb_wdata),
    .rsp_ack    (rsp_ack),
    .io_req     (io_req),
    .ipb_ack    (ipb_ack),
    .state      (fsm_state)
  );

  chan_addr_decode u_chan_addr_decode (
    .ipb_clk  (ipb_clk),
    .rst_n    (rst_n),
    .io_req   (io_req),
    .chan_req (chan_req)
  );

  //////////////////////////////
  // channels, one block per address nibble
  for (genvar i = 0; i < chan_pkg::num_chan; i++) begin : g_chan
    chan_regs #(
      .chan_id (i)
    ) u_chan_regs (
      .ipb_clk  (ipb_clk),
      .rst_n    (rst_n),
      .sel      (chan_req.sel[i]),
      .chan_req (chan_req),
      .tx_valid (chan_tx_valid[i]),
      .tx_data  (chan_tx_data[i]),
      .rd_data  (chan_rd_data[i]),
      .ack      (chan_ack[i])
    );
  end

  readback_mux u_readback_mux (
    .ipb_clk  (ipb_clk),
    .rst_n    (rst_n),
    .ack      (chan_ack),
    .rd_data  (chan_rd_data),
    .chan_req (chan_req),      // miss and access start
    .rsp_ack  (rsp_ack),
    .rsp_data (ipb_rdata)
  );

endmodule

// ==== src/chan_addr_decode.sv ====
//////////////////////////////
// channel address decoder
// addr[23:20] to a one-hot select, or a miss pulse
//////////////////////////////
`timescale 1ns/1ns

module chan_addr_decode (
  input  logic                ipb_clk,
  input  logic                rst_n,
  input  chan_pkg::io_req_t   io_req,
  output chan_pkg::chan_req_t chan_req
);

  chan_pkg::chan_field_t chan_f;
  logic                  mapped;

  assign chan_f = io_req.addr[23:20];        // bit 23 (memory space) lands in the miss range
  assign mapped = (int'(chan_f) < chan_pkg::num_chan);

  always_ff @(posedge ipb_clk) begin
    // offset and data only matter while rd/wr is up
    if (io_req.sync) begin
      chan_req.off   <= io_req.addr[7:0];
      chan_req.wdata <= io_req.wdata;
    end
    if (!rst_n) begin
      chan_req.sel  <= '0;
      chan_req.rd   <= 1'b0;
      chan_req.wr   <= 1'b0;
      chan_req.miss <= 1'b0;
    end else begin
      chan_req.sel  <= (io_req.sync && mapped) ? (chan_pkg::chan_sel_t'(1) << chan_f) : '0;
      chan_req.miss <= io_req.sync && !mapped;
      chan_req.rd   <= io_req.sync && !io_req.write;
      chan_req.wr   <= io_req.sync && io_req.write;  // also raised on a miss, nobody acts
    end
  end

endmodule

// ==== src/chan_pkg.sv ====
//////////////////////////////
// channel register front end shared definitions
// widths, register map, stage structs, bus state codes
//////////////////////////////

package chan_pkg;

  localparam int num_chan    = 4;            // channel register blocks on the bus
  localparam int ack_timeout = 16;           // cycles waited in st_wait_ack before giving up

  //////////////////////////////
  // widths that carry a meaning
  typedef logic [23:0]         ipb_addr_t;   // slave address, top nibble picks the channel
  typedef logic [31:0]         ipb_data_t;   // bus data, tx words, counters
  typedef logic [3:0]          chan_field_t; // addr[23:20]
  typedef logic [7:0]          reg_off_t;    // addr[7:0], one word per offset
  typedef logic [num_chan-1:0] chan_sel_t;   // one-hot channel select
  typedef logic [4:0]          tmo_cnt_t;    // must reach ack_timeout

  //////////////////////////////
  // register map inside one channel
  localparam reg_off_t reg_ctrl    = 8'd0;   // r/w
  localparam reg_off_t reg_scratch = 8'd1;   // r/w
  localparam reg_off_t reg_count   = 8'd2;   // ro, tx words seen
  localparam reg_off_t reg_last    = 8'd3;   // ro, last tx word
  localparam reg_off_t reg_ident   = 8'd4;   // ro, base plus channel number

  localparam int ctrl_en_bit  = 0;           // count enable
  localparam int ctrl_clr_bit = 1;           // clear pulse, never stored

  localparam ipb_data_t ident_base = 32'hc4a0_0000;

  //////////////////////////////
  // stage outputs
  // bus state machine -> decoder
  typedef struct packed {
    logic      sync;    // one-cycle start of an access
    logic      write;   // direction, latched with the strobe
    ipb_addr_t addr;
    ipb_data_t wdata;
  } io_req_t;

  // decoder -> channels and readback mux
  typedef struct packed {
    chan_sel_t sel;     // one-hot, zero on a miss
    logic      rd;      // one-cycle read pulse
    logic      wr;      // one-cycle write pulse
    logic      miss;    // channel field not mapped
    reg_off_t  off;
    ipb_data_t wdata;
  } chan_req_t;

  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_issue    = 2'd1,
    st_wait_ack = 2'd2,
    st_release  = 2'd3
  } ipb_state_e;

endpackage

// ==== src/chan_regs.sv ====
//////////////////////////////
// one channel's register block
// ctrl, scratch, tx word counter, last word capture, ident
//////////////////////////////
`timescale 1ns/1ns

module chan_regs #(
  parameter int chan_id = 0                  // lands in the low nibble of reg_ident
) (
  input  logic                ipb_clk,
  input  logic                rst_n,
  input  logic                sel,           // this channel's bit of chan_req.sel
  input  chan_pkg::chan_req_t chan_req,
  input  logic                tx_valid,      // plain one-cycle strobe, no back-pressure
  input  chan_pkg::ipb_data_t tx_data,
  output chan_pkg::ipb_data_t rd_data,
  output logic                ack
);

  chan_pkg::ipb_data_t ctrl;
  chan_pkg::ipb_data_t scratch;
  chan_pkg::ipb_data_t count;
  chan_pkg::ipb_data_t last;
  chan_pkg::ipb_data_t ident;
  chan_pkg::ipb_data_t rd_word;              // addressed word before the output flop
  logic                wr_hit;               // this channel written this cycle
  logic                clr;                  // counter clear request
  logic                cnt_en;

  assign ident  = {chan_pkg::ident_base[31:4], 4'(chan_id)};
  assign wr_hit = sel && chan_req.wr;
  assign clr    = wr_hit && (chan_req.off == chan_pkg::reg_ctrl)
                  && chan_req.wdata[chan_pkg::ctrl_clr_bit];
  assign cnt_en = ctrl[chan_pkg::ctrl_en_bit];

  //////////////////////////////
  // bus writable registers
  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      ctrl    <= '0;
      scratch <= '0;
    end else if (wr_hit) begin
      case (chan_req.off)
        chan_pkg::reg_ctrl: begin
          ctrl <= chan_req.wdata;
          ctrl[chan_pkg::ctrl_clr_bit] <= 1'b0;   // clear is a pulse, reads back 0
        end
        chan_pkg::reg_scratch: scratch <= chan_req.wdata;
        default: ;                               // ro or unlisted, write dropped
      endcase
    end
  end

  //////////////////////////////
  // tx word counter and capture
  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      count <= '0;
      last  <= '0;
    end else begin
      if (clr) begin
        count <= '0;                             // clear beats a same-cycle strobe
      end else if (tx_valid && cnt_en) begin
        count <= count + 1'b1;
      end
      if (tx_valid && cnt_en) begin
        last <= tx_data;                         // capture is not affected by clear
      end
    end
  end

  //////////////////////////////
  // readback
  always_comb begin
    case (chan_req.off)
      chan_pkg::reg_ctrl:    rd_word = ctrl;
      chan_pkg::reg_scratch: rd_word = scratch;
      chan_pkg::reg_count:   rd_word = count;
      chan_pkg::reg_last:    rd_word = last;
      chan_pkg::reg_ident:   rd_word = ident;
      default:               rd_word = '0;       // unlisted offsets read zero
    endcase
  end

  always_ff @(posedge ipb_clk) begin
    rd_data <= (sel && chan_req.rd) ? rd_word : '0;  // zero on writes
  end

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= sel && (chan_req.rd || chan_req.wr);  // high after E0+3
    end
  end

endmodule

// ==== src/ipb_io_fsm.sv ====
//////////////////////////////
// ipbus slave state machine
// latches the held strobe, fires one sync pulse, returns one ack
//////////////////////////////
`timescale 1ns/1ns

module ipb_io_fsm (
  input  logic                  ipb_clk,
  input  logic                  rst_n,
  input  logic                  ipb_strobe,   // held by the master until ack
  input  logic                  ipb_write,
  input  chan_pkg::ipb_addr_t   ipb_addr,
  input  chan_pkg::ipb_data_t   ipb_wdata,
  input  logic                  rsp_ack,      // from the readback mux
  output chan_pkg::io_req_t     io_req,
  output logic                  ipb_ack,      // one-cycle pulse to the master
  output chan_pkg::ipb_state_e  state
);

  chan_pkg::tmo_cnt_t tmo_cnt;                // cycles spent in st_wait_ack
  logic               tmo_hit;

  assign tmo_hit = (tmo_cnt == chan_pkg::tmo_cnt_t'(chan_pkg::ack_timeout));

  //////////////////////////////
  // request latch, payload only
  always_ff @(posedge ipb_clk) begin
    if (state == chan_pkg::st_idle && ipb_strobe) begin
      io_req.write <= ipb_write;
      io_req.addr  <= ipb_addr;
      io_req.wdata <= ipb_wdata;
    end
  end

  //////////////////////////////
  // control
  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      state       <= chan_pkg::st_idle;
      io_req.sync <= 1'b0;
      ipb_ack     <= 1'b0;
      tmo_cnt     <= '0;
    end else begin
      io_req.sync <= 1'b0;                    // pulses unless set below
      ipb_ack     <= 1'b0;
      case (state)
        chan_pkg::st_idle: begin
          if (ipb_strobe) begin
            state <= chan_pkg::st_issue;      // E0, request captured
          end
        end
        chan_pkg::st_issue: begin
          io_req.sync <= 1'b1;                // high after E0+1
          tmo_cnt     <= '0;
          state       <= chan_pkg::st_wait_ack;
        end
        chan_pkg::st_wait_ack: begin
          // normal path answers at E0+5, the timeout only guards a lost ack
          if (rsp_ack || tmo_hit) begin
            ipb_ack <= 1'b1;
            state   <= chan_pkg::st_release;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        chan_pkg::st_release: begin
          // a strobe still held here belongs to the access just served
          if (!ipb_strobe) begin
            state <= chan_pkg::st_idle;
          end
        end
        default: state <= chan_pkg::st_idle;
      endcase
    end
  end

endmodule

// ==== src/readback_mux.sv ====
//////////////////////////////
// readback mux
// registers the answering channel's data and the combined ack
//////////////////////////////
`timescale 1ns/1ns

module readback_mux (
  input  logic                                            ipb_clk,
  input  logic                                            rst_n,
  input  chan_pkg::chan_sel_t                             ack,
  input  chan_pkg::ipb_data_t [chan_pkg::num_chan-1:0]    rd_data,
  input  chan_pkg::chan_req_t                             chan_req,
  output logic                                            rsp_ack,
  output chan_pkg::ipb_data_t                             rsp_data
);

  logic                miss_q;               // miss lined up with the channel acks
  chan_pkg::ipb_data_t ack_data;             // OR of the acking channels' words

  always_comb begin
    ack_data = '0;
    for (int i = 0; i < chan_pkg::num_chan; i++) begin
      if (ack[i]) begin
        ack_data = ack_data | rd_data[i];    // select is one-hot
      end
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      miss_q  <= 1'b0;
      rsp_ack <= 1'b0;
    end else begin
      miss_q  <= chan_req.miss;
      rsp_ack <= (|ack) || miss_q;           // high after E0+4
    end
  end

  // data holds after the ack so it is still there with ipb_ack
  always_ff @(posedge ipb_clk) begin
    if (chan_req.rd || chan_req.wr) begin
      rsp_data <= '0;                        // new access starts from zero, a timeout reads 0
    end else if (|ack) begin
      rsp_data <= ack_data;
    end
  end

endmodule
